// File: design/core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// width of a data word and of every ALU operand
`define XLEN 32

// architectural registers, register 0 is hardwired to zero
`define NUM_REGS 32

// reservation queue slots, also the credit count the issue stage starts with
`define RS_DEPTH 4

// credit counter width, must hold the value RS_DEPTH itself
`define CREDIT_W 3

`endif

// File: design/uop_pkg.sv
package uop_pkg;

    // top six bits of a micro-op, unlisted codes behave as noop
    typedef enum logic [5:0] {
        op_noop    = 6'd0,
        op_alu_reg = 6'd1,
        op_addi    = 6'd2,
        op_andi    = 6'd3,
        op_ori     = 6'd4,
        op_xori    = 6'd5
    } opcode_t;

    // ALU function codes, anything else produces zero
    typedef enum logic [5:0] {
        fn_add = 6'd0,
        fn_sub = 6'd1,
        fn_and = 6'd2,
        fn_or  = 6'd3,
        fn_xor = 6'd4,
        fn_sll = 6'd5,
        fn_srl = 6'd6,
        fn_slt = 6'd7
    } alu_fn_t;

    typedef struct packed {
        logic [4:0] src_b;
        logic [4:0] pad;
        alu_fn_t    fn;
    } r_form_t;

    // low half of the word, the opcode picks the view
    typedef union packed {
        r_form_t     r_form;
        logic [15:0] i_form;
    } operand_u;

    typedef struct packed {
        opcode_t    opcode;
        logic [4:0] target;
        logic [4:0] src_a;
        operand_u   operands;
    } uop_t;

endpackage

// File: design/core_pkg.sv
`include "core_macros.svh"

package core_pkg;

    typedef logic [$clog2(`NUM_REGS)-1:0] reg_idx_t;

    typedef logic [`XLEN-1:0] data_t;

    // one reservation queue slot, operands already read
    typedef struct packed {
        uop_pkg::alu_fn_t fn;
        reg_idx_t         target;
        data_t            op_a;
        data_t            op_b;
    } rs_entry_t;

endpackage

// File: design/register_file.sv
`timescale 1ns/10ps
`include "core_macros.svh"

module register_file (
    input  logic              clk,
    input  logic              reset,
    input  core_pkg::reg_idx_t rd_addr_a,
    input  core_pkg::reg_idx_t rd_addr_b,
    input  logic              wr_en,
    input  core_pkg::reg_idx_t wr_addr,
    input  core_pkg::data_t    wr_data,
    output core_pkg::data_t    rd_data_a,
    output core_pkg::data_t    rd_data_b
);
    import core_pkg::*;

    data_t regs [`NUM_REGS];

    logic wr_live;

    assign wr_live = wr_en && (wr_addr != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // same-cycle write bypasses to the read ports
    assign rd_data_a = (rd_addr_a == '0) ? '0 :
                       (wr_live && wr_addr == rd_addr_a) ? wr_data : regs[rd_addr_a];
    assign rd_data_b = (rd_addr_b == '0) ? '0 :
                       (wr_live && wr_addr == rd_addr_b) ? wr_data : regs[rd_addr_b];

endmodule

// File: design/uop_issue.sv
`timescale 1ns/10ps
`include "core_macros.svh"

module uop_issue (
    input  logic               clk,
    input  logic               reset,
    input  logic               uop_valid,
    input  uop_pkg::uop_t      uop,
    output logic               uop_ready,
    output core_pkg::reg_idx_t rd_addr_a,
    output core_pkg::reg_idx_t rd_addr_b,
    input  core_pkg::data_t    rd_data_a,
    input  core_pkg::data_t    rd_data_b,
    output logic               issue_valid,
    output uop_pkg::alu_fn_t   issue_fn,
    output core_pkg::reg_idx_t issue_target,
    output core_pkg::data_t    issue_op_a,
    output core_pkg::data_t    issue_op_b,
    input  logic               credit_return,
    input  logic               wb_valid,
    input  core_pkg::reg_idx_t wb_reg
);
    import uop_pkg::*;
    import core_pkg::*;

    logic                 accept_en;
    logic                 dec_valid;
    uop_t                 dec_uop;
    logic [`NUM_REGS-1:0] busy;
    logic [`CREDIT_W-1:0] credits;

    logic  is_noop;
    logic  uses_b;
    logic  a_wait;
    logic  b_wait;
    logic  t_wait;
    logic  leaving;
    data_t imm_sext;
    data_t imm_zext;

    // a pending writeback in this very cycle no longer counts as busy
    function automatic logic reg_waiting(input reg_idx_t idx);
        return (idx != '0) && busy[idx] && !(wb_valid && wb_reg == idx);
    endfunction

    assign imm_sext = {{(`XLEN - 16){dec_uop.operands.i_form[15]}}, dec_uop.operands.i_form};
    assign imm_zext = {{(`XLEN - 16){1'b0}}, dec_uop.operands.i_form};

    assign rd_addr_a = dec_uop.src_a;
    assign rd_addr_b = dec_uop.operands.r_form.src_b;

    always_comb begin
        is_noop    = 1'b0;
        uses_b     = 1'b0;
        issue_fn   = fn_add;
        issue_op_b = imm_zext;
        case (dec_uop.opcode)
            op_alu_reg: begin
                uses_b     = 1'b1;
                issue_fn   = dec_uop.operands.r_form.fn;
                issue_op_b = rd_data_b;
            end
            op_addi: begin
                issue_op_b = imm_sext;
            end
            op_andi: issue_fn = fn_and;
            op_ori:  issue_fn = fn_or;
            op_xori: issue_fn = fn_xor;
            default: is_noop = 1'b1;
        endcase
    end

    // target check keeps a second writer from racing an older one to the same register
    always_comb begin
        a_wait = reg_waiting(dec_uop.src_a);
        b_wait = uses_b && reg_waiting(dec_uop.operands.r_form.src_b);
        t_wait = reg_waiting(dec_uop.target);
    end

    assign issue_target = dec_uop.target;
    assign issue_op_a   = rd_data_a;

    assign issue_valid = dec_valid && !is_noop && !a_wait && !b_wait && !t_wait &&
                         (credits != '0);
    assign leaving     = dec_valid && (is_noop || issue_valid);
    assign uop_ready   = accept_en && (!dec_valid || leaving);

    always_ff @(posedge clk) begin
        if (reset) begin
            accept_en <= 1'b0;
            dec_valid <= 1'b0;
        end else begin
            // input port opens the cycle after reset is released
            accept_en <= 1'b1;
            if (uop_valid && uop_ready) begin
                dec_valid <= 1'b1;
            end else if (leaving) begin
                dec_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (uop_valid && uop_ready) begin
            dec_uop <= uop;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            credits <= `CREDIT_W'(`RS_DEPTH);
        end else begin
            credits <= credits + `CREDIT_W'(credit_return) - `CREDIT_W'(issue_valid);
        end
    end

    // scoreboard, a new producer wins over a retiring one
    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= '0;
        end else begin
            if (wb_valid) begin
                busy[wb_reg] <= 1'b0;
            end
            if (issue_valid && issue_target != '0) begin
                busy[issue_target] <= 1'b1;
            end
        end
    end

endmodule

// File: design/reservation_queue.sv
`timescale 1ns/10ps
`include "core_macros.svh"

module reservation_queue (
    input  logic               clk,
    input  logic               reset,
    input  logic               issue_valid,
    input  uop_pkg::alu_fn_t   issue_fn,
    input  core_pkg::reg_idx_t issue_target,
    input  core_pkg::data_t    issue_op_a,
    input  core_pkg::data_t    issue_op_b,
    output logic               credit_return,
    output logic               exec_valid,
    output uop_pkg::alu_fn_t   exec_fn,
    output core_pkg::reg_idx_t exec_target,
    output core_pkg::data_t    exec_op_a,
    output core_pkg::data_t    exec_op_b
);
    import core_pkg::*;

    localparam int PTR_W = $clog2(`RS_DEPTH);

    rs_entry_t            slots [`RS_DEPTH];
    logic [PTR_W-1:0]     head;
    logic [PTR_W-1:0]     tail;
    logic [`CREDIT_W-1:0] count;
    logic                 pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(`RS_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // head leaves every cycle it holds something
    assign pop           = (count != '0);
    assign exec_valid    = pop;
    assign credit_return = pop;

    assign exec_fn     = slots[head].fn;
    assign exec_target = slots[head].target;
    assign exec_op_a   = slots[head].op_a;
    assign exec_op_b   = slots[head].op_b;

    // no full check, the issue credits bound the occupancy
    always_ff @(posedge clk) begin
        if (issue_valid) begin
            slots[tail] <= '{fn: issue_fn, target: issue_target,
                             op_a: issue_op_a, op_b: issue_op_b};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (issue_valid) begin
                tail <= ptr_inc(tail);
            end
            if (pop) begin
                head <= ptr_inc(head);
            end
            count <= count + `CREDIT_W'(issue_valid) - `CREDIT_W'(pop);
        end
    end

endmodule

// File: design/alu_exec.sv
`timescale 1ns/10ps
`include "core_macros.svh"

module alu_exec (
    input  logic               clk,
    input  logic               reset,
    input  logic               exec_valid,
    input  uop_pkg::alu_fn_t   exec_fn,
    input  core_pkg::reg_idx_t exec_target,
    input  core_pkg::data_t    exec_op_a,
    input  core_pkg::data_t    exec_op_b,
    output logic               wb_valid,
    output core_pkg::reg_idx_t wb_reg,
    output core_pkg::data_t    wb_value
);
    import uop_pkg::*;
    import core_pkg::*;

    localparam int SHAMT_W = $clog2(`XLEN);

    logic [SHAMT_W-1:0] shamt;
    data_t              alu_out;

    logic     s1_valid;
    reg_idx_t s1_target;
    data_t    s1_value;

    assign shamt = exec_op_b[SHAMT_W-1:0];

    always_comb begin
        case (exec_fn)
            fn_add:  alu_out = exec_op_a + exec_op_b;
            fn_sub:  alu_out = exec_op_a - exec_op_b;
            fn_and:  alu_out = exec_op_a & exec_op_b;
            fn_or:   alu_out = exec_op_a | exec_op_b;
            fn_xor:  alu_out = exec_op_a ^ exec_op_b;
            fn_sll:  alu_out = exec_op_a << shamt;
            fn_srl:  alu_out = exec_op_a >> shamt;
            fn_slt: begin
                alu_out = {{(`XLEN - 1){1'b0}}, $signed(exec_op_a) < $signed(exec_op_b)};
            end
            default: alu_out = '0;
        endcase
    end

    // stage 1 latches the computed value
    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= exec_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_target <= exec_target;
        s1_value  <= alu_out;
    end

    // stage 2 is the writeback register
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        wb_reg   <= s1_target;
        wb_value <= s1_value;
    end

endmodule

// File: design/uop_core.sv
`timescale 1ns/10ps

module uop_core (
    input  logic               clk,
    input  logic               reset,
    input  logic               uop_valid,
    input  uop_pkg::uop_t      uop,
    output logic               uop_ready,
    output logic               result_valid,
    output core_pkg::reg_idx_t result_reg,
    output core_pkg::data_t    result_value
);
    import uop_pkg::*;
    import core_pkg::*;

    reg_idx_t rd_addr_a;
    reg_idx_t rd_addr_b;
    data_t    rd_data_a;
    data_t    rd_data_b;

    logic     issue_valid;
    alu_fn_t  issue_fn;
    reg_idx_t issue_target;
    data_t    issue_op_a;
    data_t    issue_op_b;
    logic     credit_return;

    logic     exec_valid;
    alu_fn_t  exec_fn;
    reg_idx_t exec_target;
    data_t    exec_op_a;
    data_t    exec_op_b;

    logic     wb_valid;
    reg_idx_t wb_reg;
    data_t    wb_value;

    uop_issue issue0 (
        .clk, .reset, .uop_valid, .uop, .uop_ready,
        .rd_addr_a, .rd_addr_b, .rd_data_a, .rd_data_b,
        .issue_valid, .issue_fn, .issue_target, .issue_op_a, .issue_op_b,
        .credit_return, .wb_valid, .wb_reg
    );

    reservation_queue rsq0 (
        .clk, .reset,
        .issue_valid, .issue_fn, .issue_target, .issue_op_a, .issue_op_b,
        .credit_return,
        .exec_valid, .exec_fn, .exec_target, .exec_op_a, .exec_op_b
    );

    alu_exec alu0 (
        .clk, .reset,
        .exec_valid, .exec_fn, .exec_target, .exec_op_a, .exec_op_b,
        .wb_valid, .wb_reg, .wb_value
    );

    register_file rf0 (
        .clk, .reset, .rd_addr_a, .rd_addr_b,
        .wr_en(wb_valid), .wr_addr(wb_reg), .wr_data(wb_value),
        .rd_data_a, .rd_data_b
    );

    assign result_valid = wb_valid;
    assign result_reg   = wb_reg;
    assign result_value = wb_value;

endmodule

// File: verif/uop_core_assertions.sv
`timescale 1ns/10ps
`include "core_macros.svh"

module uop_core_assertions (
    input logic                 clk,
    input logic                 reset,
    input logic                 uop_valid,
    input logic                 uop_ready,
    input logic                 issue_valid,
    input logic                 credit_return,
    input logic [`CREDIT_W-1:0] credits
);
    logic                 seen_accept;
    logic [`CREDIT_W-1:0] in_flight;

    always_ff @(posedge clk) begin
        if (reset) begin
            seen_accept <= 1'b0;
        end else if (uop_valid && uop_ready) begin
            seen_accept <= 1'b1;
        end
    end

    // entries issued and not yet handed back by the queue
    always_ff @(posedge clk) begin
        if (reset) begin
            in_flight <= '0;
        end else begin
            in_flight <= in_flight + `CREDIT_W'(issue_valid) - `CREDIT_W'(credit_return);
        end
    end

    credit_limit: assert property (@(posedge clk) disable iff (reset)
        credits <= `CREDIT_W'(`RS_DEPTH)) else $error("credit count above queue depth");

    issue_needs_credit: assert property (@(posedge clk) disable iff (reset)
        issue_valid |-> in_flight < `CREDIT_W'(`RS_DEPTH))
        else $error("issue with no credit left");

    // the decode register is empty until the first transfer
    no_early_issue: assert property (@(posedge clk) disable iff (reset)
        issue_valid |-> seen_accept) else $error("issue before any micro-op was accepted");

endmodule

bind uop_issue uop_core_assertions asrt0 (
    .clk(clk), .reset(reset), .uop_valid(uop_valid), .uop_ready(uop_ready),
    .issue_valid(issue_valid), .credit_return(credit_return), .credits(credits)
);

// File: verif/uop_core_tb.sv
`timescale 1ns/10ps
`include "core_macros.svh"

module uop_core_tb;
    import uop_pkg::*;
    import core_pkg::*;

    localparam int NUM_TESTS = 5;
    localparam int DRIVE_DLY = 1;

    // stimulus word plus the writeback the reference model expects from it
    typedef struct {
        int       test;
        uop_t     word;
        logic     has_result;
        reg_idx_t reg_num;
        data_t    value;
    } row_t;

    logic     clk;
    logic     reset;
    logic     uop_valid;
    uop_t     uop;
    logic     uop_ready;
    logic     result_valid;
    reg_idx_t result_reg;
    data_t    result_value;

    row_t  rows [$];
    row_t  pending [$];
    row_t  head;
    data_t ref_regs [`NUM_REGS] = '{default: '0};
    int    test_left [1:NUM_TESTS] = '{default: 0};
    int    test_errs [1:NUM_TESTS] = '{default: 0};
    int    err_count = 0;
    int    result_count = 0;
    int    expect_count = 0;
    int    cycles = 0;
    int    timeout_limit = 0;
    int    seed = 19;
    int    errs_before;

    uop_core dut0 (
        .clk, .reset, .uop_valid, .uop, .uop_ready,
        .result_valid, .result_reg, .result_value
    );

    always #20 clk = ~clk;

    function automatic uop_t r_op(alu_fn_t fn, int rd, int ra, int rb);
        return {op_alu_reg, 5'(rd), 5'(ra), 5'(rb), 5'b0, fn};
    endfunction

    function automatic uop_t i_op(opcode_t opc, int rd, int ra, logic [15:0] imm);
        return {opc, 5'(rd), 5'(ra), imm};
    endfunction

    function automatic data_t alu_model(alu_fn_t fn, data_t a, data_t b);
        case (fn)
            fn_add:  return a + b;
            fn_sub:  return a - b;
            fn_and:  return a & b;
            fn_or:   return a | b;
            fn_xor:  return a ^ b;
            fn_sll:  return a << b[4:0];
            fn_srl:  return a >> b[4:0];
            fn_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return '0;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    // reference model runs in program order while the table is built
    task automatic add_row(input int test_num, input uop_t word);
        row_t  row;
        data_t a;
        data_t zext;
        a    = ref_regs[word.src_a];
        zext = {16'h0, word.operands.i_form};
        row  = '{test_num, word, 1'b1, word.target, '0};
        case (word.opcode)
            op_alu_reg: begin
                row.value = alu_model(word.operands.r_form.fn, a,
                                      ref_regs[word.operands.r_form.src_b]);
            end
            op_addi: row.value = a + {{16{word.operands.i_form[15]}}, word.operands.i_form};
            op_andi: row.value = a & zext;
            op_ori:  row.value = a | zext;
            op_xori: row.value = a ^ zext;
            default: row.has_result = 1'b0;
        endcase
        if (row.has_result) begin
            expect_count++;
            test_left[test_num]++;
            if (word.target != '0) begin
                ref_regs[word.target] = row.value;
            end
        end
        rows.push_back(row);
    endtask

    // uop_ready sampled mid-cycle decides the transfer at the next edge
    task automatic wait_accept();
        logic taken;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = uop_ready;
            @(posedge clk);
            #DRIVE_DLY;
        end
    endtask

    // outputs stay quiet while reset is held
    always @(negedge clk) begin
        if (reset) begin
            check_value("uop_ready", uop_ready, 32'd0);
            check_value("result_valid", result_valid, 32'd0);
        end
    end

    always @(negedge clk) begin
        if (!reset && result_valid) begin
            result_count++;
            if (pending.size() == 0) begin
                $display("result for register %0d at %0t arrived with nothing expected",
                         result_reg, $time);
                err_count++;
            end else begin
                head        = pending.pop_front();
                errs_before = err_count;
                check_value("result_reg", result_reg, head.reg_num);
                check_value("result_value", result_value, head.value);
                test_errs[head.test] += err_count - errs_before;
                test_left[head.test]--;
                if (test_left[head.test] == 0) begin
                    $display("test %0d finished, %0d errors", head.test, test_errs[head.test]);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > timeout_limit) begin
            $display("run stopped after %0d cycles, %0d results never arrived",
                     cycles, pending.size());
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        logic [15:0] imm;
        int          src;
        int          opc;
        clk       = 1'b0;
        reset     = 1'b1;
        uop_valid = 1'b0;
        uop       = '0;
        // two loaded sources followed by every register-form function
        add_row(1, i_op(op_addi, 1, 0, 16'h1234));
        add_row(1, i_op(op_addi, 2, 0, 16'hfffd));
        add_row(1, r_op(fn_add, 3, 1, 2));
        add_row(1, r_op(fn_sub, 4, 1, 2));
        add_row(1, r_op(fn_and, 5, 1, 2));
        add_row(1, r_op(fn_or, 6, 1, 2));
        add_row(1, r_op(fn_xor, 7, 1, 2));
        add_row(1, r_op(fn_sll, 8, 1, 2));
        add_row(1, r_op(fn_srl, 9, 2, 1));
        add_row(1, r_op(fn_slt, 10, 2, 1));
        // bit 15 set in every immediate
        add_row(2, i_op(op_addi, 11, 1, 16'h8000));
        add_row(2, i_op(op_andi, 12, 2, 16'h8f0f));
        add_row(2, i_op(op_ori, 13, 1, 16'h8001));
        add_row(2, i_op(op_xori, 14, 2, 16'hffff));
        // dependent chain
        add_row(3, i_op(op_addi, 15, 0, 16'h0003));
        add_row(3, i_op(op_addi, 16, 15, 16'h0002));
        add_row(3, r_op(fn_sll, 17, 16, 16));
        add_row(3, r_op(fn_sub, 18, 17, 1));
        // noop, write to r0, unknown opcode naming r18, then r0 read back
        add_row(4, '0);
        add_row(4, i_op(op_addi, 0, 1, 16'h0007));
        add_row(4, 32'hfe5f_0001);
        add_row(4, r_op(fn_add, 19, 0, 1));
        // random burst whose sources 1..18 never overlap targets 20..31
        for (int k = 0; k < 3 * `RS_DEPTH; k++) begin
            src = 1 + ($unsigned($random(seed)) % 18);
            imm = 16'($random(seed));
            opc = 1 + ($unsigned($random(seed)) % 5);
            if (opc == 1) begin
                add_row(5, r_op(alu_fn_t'(6'(imm[2:0])), 20 + k, src, 1 + imm[7:4]));
            end else begin
                add_row(5, i_op(opcode_t'(6'(opc)), 20 + k, src, imm));
            end
        end
        timeout_limit = 40 * rows.size() + 100;
        repeat (8) @(posedge clk);
        #DRIVE_DLY;
        reset = 1'b0;
        foreach (rows[i]) begin
            if (rows[i].has_result) begin
                pending.push_back(rows[i]);
            end
            uop       = rows[i].word;
            uop_valid = 1'b1;
            wait_accept();
        end
        uop_valid = 1'b0;
        while (pending.size() != 0) begin
            @(negedge clk);
        end
        // room for a stray result after the last expected one
        repeat (10) @(negedge clk);
        check_value("result_count", result_count, expect_count);
        $display("%0d tests, %0d rows, %0d results, %0d errors",
                 NUM_TESTS, rows.size(), result_count, err_count);
        if (err_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+design
design/uop_pkg.sv
design/core_pkg.sv
design/register_file.sv
design/uop_issue.sv
design/reservation_queue.sv
design/alu_exec.sv
design/uop_core.sv
verif/uop_core_assertions.sv
verif/uop_core_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module uop_core_tb -f files.f

# the log decides the outcome, so a nonzero simulator exit is not fatal here
./obj_dir/Vuop_core_tb > sim.log 2>&1 || true
cat sim.log

grep -q "^Regression passed$" sim.log
